//--- verilog/keypad_pkg.sv
package keypad_pkg;

  // Event FIFO sizing
  localparam int KEY_FIFO_DEPTH = 4;
  // Pointer needs at least one bit even for a single entry
  localparam int KEY_FIFO_PTR_W = (KEY_FIFO_DEPTH > 1) ? $clog2(KEY_FIFO_DEPTH) : 1;
  // Level must reach the full count, not just DEPTH-1
  localparam int KEY_FIFO_LVL_W = $clog2(KEY_FIFO_DEPTH + 1);

  // Keypad matrix lines
  // Row 1 means pressed
  typedef logic [3:0] row_t;
  // Columns are driven active low
  typedef logic [3:0] col_t;
  // Rows in the high nibble, inverted columns in the low nibble
  typedef logic [7:0] key_pos_t;
  // Code is 4*row_index + col_index, index 0 at bit 3
  typedef logic [3:0] key_code_t;

  typedef struct packed {
    key_code_t code;
    logic      multi;
  } key_event_t;

  typedef logic [KEY_FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [KEY_FIFO_LVL_W-1:0] fifo_level_t;

  // AXI4-Lite widths
  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // Register map, byte addresses
  localparam axil_addr_t REG_CTRL   = 4'h0;
  localparam axil_addr_t REG_STATUS = 4'h4;
  localparam axil_addr_t REG_KEY    = 4'h8;

  // Field positions inside the key register
  localparam int KEY_MULTI_BIT = 4;
  localparam int KEY_VALID_BIT = 8;
  // Status level field starts here
  localparam int STATUS_LVL_LSB = 4;

  // Master-driven channel fields
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // Slave-driven channel fields, responses are always OKAY
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    logic       rvalid;
  } axil_rsp_t;

  typedef enum logic {IDLE, WAIT_RELEASE} entry_state_t;
  typedef enum logic [1:0] {READY, WRESP, RDATA} axil_state_t;

endpackage

//--- verilog/keypad_scanner.sv
module keypad_scanner import keypad_pkg::*; (
  input  logic     clk,
  input  logic     nRst,
  input  logic     enable,
  input  logic     mode,
  input  row_t     row,
  output col_t     col,
  output key_pos_t key_pos,
  output logic     strobe
);

  // Two synchronizer stages and one delay stage for the edge
  row_t row_meta;
  row_t row_sync;
  row_t row_dly;
  col_t col_next;

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      row_meta <= '0;
      row_sync <= '0;
      row_dly  <= '0;
      // All columns released, nothing can be read
      col      <= 4'b1111;
    end else begin
      row_meta <= row;
      row_sync <= row_meta;
      row_dly  <= row_sync;
      col      <= col_next;
    end
  end

  // Column rotation
  always_comb begin
    col_next = col;
    if (!mode) begin
      // Scan mode off parks every column high
      col_next = 4'b1111;
    end else if (|row) begin
      // Key under the active column, stay on it until release
      col_next = col;
    end else if (enable) begin
      case (col)
        4'b1111: col_next = 4'b0111;
        4'b0111: col_next = 4'b1011;
        4'b1011: col_next = 4'b1101;
        4'b1101: col_next = 4'b1110;
        4'b1110: col_next = 4'b0111;
        // Illegal pattern, recover to idle
        default: col_next = 4'b1111;
      endcase
    end
  end

  // One pulse per rising row bit, three edges after the pin moves
  assign strobe = |(row_sync & ~row_dly);

  // Raw position only when a row and a driven column are both present
  always_comb begin
    if ((|row) && (|(~col))) begin
      key_pos = {row, ~col};
    end else begin
      key_pos = '0;
    end
  end

  // Never more than one column driven low
  a_col_single_low: assert property (
    @(posedge clk) disable iff (!nRst)
    (col == 4'b1111) || $onehot(~col)
  ) else $error("keypad_scanner: more than one column driven low");

endmodule

//--- verilog/key_entry_fsm.sv
module key_entry_fsm import keypad_pkg::*; (
  input  logic       clk,
  input  logic       nRst,
  input  key_pos_t   key_pos,
  input  logic       strobe,
  input  logic       ev_ready,
  input  logic       overflow_clr,
  output logic       ev_valid,
  output key_event_t ev_data,
  output logic       overflow
);

  entry_state_t state;
  entry_state_t state_next;
  // New press accepted this cycle
  logic         hit;
  // Rows have let go
  logic         released;

  // One-hot halves to key code
  function automatic key_event_t encode(key_pos_t pos);
    key_event_t ev;
    row_t       rows;
    col_t       cols;
    ev   = '0;
    rows = pos[7:4];
    cols = pos[3:0];
    // Walk upward so bit 3 (index 0) overrides lower rows
    for (int i = 0; i < 4; i++) begin
      if (rows[i]) begin
        ev.code[3:2] = 2'(3 - i);
      end
      if (cols[i]) begin
        ev.code[1:0] = 2'(3 - i);
      end
    end
    // Two or more rows in one column
    ev.multi = ($countones(rows) > 1);
    return ev;
  endfunction

  assign hit      = (state == IDLE) && strobe && (key_pos != '0);
  assign released = (key_pos[7:4] == '0);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (hit) begin
          state_next = WAIT_RELEASE;
        end
      end
      WAIT_RELEASE: begin
        // Further strobes are ignored until the key lets go
        if (released) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state    <= IDLE;
      ev_valid <= 1'b0;
      overflow <= 1'b0;
    end else begin
      state    <= state_next;
      // Single cycle offer, never held
      ev_valid <= hit;
      // Dropped event wins over a clear in the same cycle
      if (ev_valid && !ev_ready) begin
        overflow <= 1'b1;
      end else if (overflow_clr) begin
        overflow <= 1'b0;
      end
    end
  end

  // Event payload
  always_ff @(posedge clk) begin
    if (hit) begin
      ev_data <= encode(key_pos);
    end
  end

  a_ev_one_cycle: assert property (
    @(posedge clk) disable iff (!nRst)
    ev_valid |=> !ev_valid
  ) else $error("key_entry_fsm: ev_valid held for two cycles");

endmodule

//--- verilog/key_event_fifo.sv
module key_event_fifo import keypad_pkg::*; (
  input  logic        clk,
  input  logic        nRst,
  input  logic        push,
  input  key_event_t  push_data,
  input  logic        pop,
  output logic        push_ready,
  output key_event_t  pop_data,
  output logic        empty,
  output fifo_level_t level
);

  // Storage
  key_event_t mem [KEY_FIFO_DEPTH];
  fifo_ptr_t  wr_ptr;
  fifo_ptr_t  rd_ptr;
  logic       do_push;
  logic       do_pop;

  // Wrap at DEPTH so non power of two depths also work
  function automatic fifo_ptr_t ptr_inc(fifo_ptr_t p);
    return (p == fifo_ptr_t'(KEY_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push_ready = (level != fifo_level_t'(KEY_FIFO_DEPTH));
  assign empty      = (level == '0);
  assign do_push    = push && push_ready;
  assign do_pop     = pop && !empty;
  // Head entry, shown while not empty
  assign pop_data   = mem[rd_ptr];

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Register slave must never pop an empty FIFO
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!nRst)
    pop |-> !empty
  ) else $error("key_event_fifo: pop while empty");

  // A refused push leaves the FIFO full
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!nRst)
    (push && !push_ready && !pop) |=> (level == fifo_level_t'(KEY_FIFO_DEPTH))
  ) else $error("key_event_fifo: push accepted while full");

endmodule

//--- verilog/keypad_axil_slave.sv
module keypad_axil_slave import keypad_pkg::*; (
  input  logic        clk,
  input  logic        nRst,
  input  axil_req_t   axil_req,
  input  key_event_t  pop_data,
  input  logic        fifo_empty,
  input  fifo_level_t level,
  input  logic        overflow,
  output axil_rsp_t   axil_rsp,
  output logic        scan_enable,
  output logic        scan_mode,
  output logic        pop,
  output logic        overflow_clr
);

  axil_state_t state;
  // Handshakes, both only possible in READY
  logic        wr_hs;
  logic        rd_hs;
  // Control register bits
  logic        ctrl_enable;
  logic        ctrl_mode;
  axil_data_t  rd_word;
  axil_data_t  rdata_q;

  // Write needs address and data together; it beats a read
  assign wr_hs = (state == READY) && axil_req.awvalid && axil_req.wvalid;
  assign rd_hs = (state == READY) && axil_req.arvalid &&
                 !(axil_req.awvalid && axil_req.wvalid);

  assign axil_rsp.awready = wr_hs;
  assign axil_rsp.wready  = wr_hs;
  assign axil_rsp.arready = rd_hs;
  assign axil_rsp.bvalid  = (state == WRESP);
  assign axil_rsp.rvalid  = (state == RDATA);
  assign axil_rsp.rdata   = rdata_q;

  // Key read consumes the head entry at the handshake
  assign pop = rd_hs && (axil_req.araddr == REG_KEY) && !fifo_empty;
  // Write-one-to-clear on status bit 1
  assign overflow_clr = wr_hs && (axil_req.awaddr == REG_STATUS) && axil_req.wdata[1];

  assign scan_enable = ctrl_enable;
  assign scan_mode   = ctrl_mode;

  // Read data mux
  always_comb begin
    rd_word = '0;
    case (axil_req.araddr)
      REG_CTRL: begin
        rd_word[0] = ctrl_enable;
        rd_word[1] = ctrl_mode;
      end
      REG_STATUS: begin
        rd_word[0] = !fifo_empty;
        rd_word[1] = overflow;
        rd_word[STATUS_LVL_LSB +: $bits(fifo_level_t)] = level;
      end
      REG_KEY: begin
        // Empty FIFO reads back as all zero
        if (!fifo_empty) begin
          rd_word[3:0]           = pop_data.code;
          rd_word[KEY_MULTI_BIT] = pop_data.multi;
          rd_word[KEY_VALID_BIT] = 1'b1;
        end
      end
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state       <= READY;
      ctrl_enable <= 1'b0;
      ctrl_mode   <= 1'b0;
    end else begin
      case (state)
        READY: begin
          if (wr_hs) begin
            state <= WRESP;
            if (axil_req.awaddr == REG_CTRL) begin
              ctrl_enable <= axil_req.wdata[0];
              ctrl_mode   <= axil_req.wdata[1];
            end
          end else if (rd_hs) begin
            state <= RDATA;
          end
        end
        // Hold the response until the master takes it
        WRESP: if (axil_req.bready) state <= READY;
        RDATA: if (axil_req.rready) state <= READY;
        default: state <= READY;
      endcase
    end
  end

  // Capture read data with the handshake, before the pop moves the head
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata_q <= rd_word;
    end
  end

  a_one_response: assert property (
    @(posedge clk) disable iff (!nRst)
    !(axil_rsp.bvalid && axil_rsp.rvalid)
  ) else $error("keypad_axil_slave: bvalid and rvalid high together");

endmodule

//--- verilog/keypad_ctrl_top.sv
module keypad_ctrl_top import keypad_pkg::*; (
  input  logic      clk,
  input  logic      nRst,
  input  row_t      row,
  output col_t      col,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp
);

  // Control from the register slave
  logic        scan_enable;
  logic        scan_mode;
  // Scanner to entry machine
  key_pos_t    key_pos;
  logic        strobe;
  // Entry machine to FIFO
  logic        ev_valid;
  logic        ev_ready;
  key_event_t  ev_data;
  // Overflow flag and its clear
  logic        overflow;
  logic        overflow_clr;
  // FIFO to register slave
  key_event_t  pop_data;
  logic        fifo_empty;
  fifo_level_t level;
  logic        pop;

  // Producer side
  keypad_scanner keypad_scanner_i (
    .clk     (clk),
    .nRst    (nRst),
    .enable  (scan_enable),
    .mode    (scan_mode),
    .row     (row),
    .col     (col),
    .key_pos (key_pos),
    .strobe  (strobe)
  );

  key_entry_fsm key_entry_fsm_i (
    .clk          (clk),
    .nRst         (nRst),
    .key_pos      (key_pos),
    .strobe       (strobe),
    .ev_ready     (ev_ready),
    .overflow_clr (overflow_clr),
    .ev_valid     (ev_valid),
    .ev_data      (ev_data),
    .overflow     (overflow)
  );

  // Buffer
  key_event_fifo key_event_fifo_i (
    .clk        (clk),
    .nRst       (nRst),
    .push       (ev_valid),
    .push_data  (ev_data),
    .pop        (pop),
    .push_ready (ev_ready),
    .pop_data   (pop_data),
    .empty      (fifo_empty),
    .level      (level)
  );

  // Consumer
  keypad_axil_slave keypad_axil_slave_i (
    .clk          (clk),
    .nRst         (nRst),
    .axil_req     (axil_req),
    .pop_data     (pop_data),
    .fifo_empty   (fifo_empty),
    .level        (level),
    .overflow     (overflow),
    .axil_rsp     (axil_rsp),
    .scan_enable  (scan_enable),
    .scan_mode    (scan_mode),
    .pop          (pop),
    .overflow_clr (overflow_clr)
  );

endmodule

//--- tb/keypad_checker.sv
module keypad_checker import keypad_pkg::*; (
  input logic      clk,
  input logic      nRst,
  input col_t      col,
  input axil_req_t axil_req,
  input axil_rsp_t axil_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  string      test_name = "none";
  int         value_errs = 0;
  int         other_errs = 0;
  int         key_reads = 0;
  // Key register words still to be read, oldest first
  axil_data_t exp_q[$];
  // Address of the read in flight
  axil_addr_t rd_addr = REG_CTRL;

  // Expected key word from the row and column lines of a press
  function automatic axil_data_t key_ref(row_t rows, col_t cols);
    axil_data_t word;
    int         ri;
    int         ci;
    word = '0;
    ri = 0;
    ci = 0;
    // Index k sits at bit 3-k, the lowest pressed index wins
    for (int k = 3; k >= 0; k--) begin
      if (rows[3-k]) ri = k;
      if (!cols[3-k]) ci = k;
    end
    word[3:0] = 4'(4 * ri + ci);
    word[4]   = ($countones(rows) > 1);
    word[8]   = 1'b1;
    return word;
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
  endtask

  task automatic expect_key(input row_t rows, input col_t cols);
    exp_q.push_back(key_ref(rows, cols));
  endtask

  task automatic check_value(input string what, input axil_data_t exp, input axil_data_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_col(input string what, input col_t exp);
    if (col !== exp) begin
      value_errs++;
      $display("ERR %s %s: expected %b actual %b", test_name, what, exp, col);
    end
  endtask

  task automatic note_failure(input string msg);
    other_errs++;
    $display("Error in %s at %0t: %s", test_name, $time, msg);
  endtask

  // Empty queue means the DUT must answer with an all-zero word
  task automatic compare_key(input axil_data_t act);
    axil_data_t exp;
    exp = (exp_q.size() > 0) ? exp_q.pop_front() : '0;
    key_reads++;
    check_value("key read", exp, act);
  endtask

  // Watch the read channel and compare every key register read
  always @(posedge clk) begin
    if (nRst) begin
      if (axil_req.arvalid && axil_rsp.arready) begin
        rd_addr <= axil_req.araddr;
      end
      if (axil_rsp.rvalid && axil_req.rready && rd_addr == REG_KEY) begin
        compare_key(axil_rsp.rdata);
      end
    end
  end

  function automatic int error_total();
    return value_errs + other_errs;
  endfunction

  task automatic report();
    if (exp_q.size() != 0) begin
      note_failure("some expected key events were never read back");
    end
    $display("Checker: %0d key reads, %0d value errors, %0d other errors",
             key_reads, value_errs, other_errs);
  endtask

endmodule

//--- tb/tb_keypad_ctrl.sv
module tb_keypad_ctrl import keypad_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // Handshake limit in cycles, status poll limit in reads
  localparam int HS_LIMIT   = 50;
  localparam int POLL_LIMIT = 40;

  logic        clk;
  logic        nRst;
  row_t        row;
  col_t        col;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  // Pressed keys, bit 4*r+c
  logic [15:0] pressed;
  axil_data_t  rd;
  int          order [16];
  int          r0;
  int          r1;
  int          c0;
  int          j;
  int          tmp;

  keypad_ctrl_top keypad_ctrl_top_i (
    .clk      (clk),
    .nRst     (nRst),
    .row      (row),
    .col      (col),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  keypad_checker keypad_checker_i (
    .clk      (clk),
    .nRst     (nRst),
    .col      (col),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Matrix model, a key shorts its row to a low column
  always_comb begin
    row = '0;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        if (pressed[4*r+c] && !col[3-c]) row[3-r] = 1'b1;
      end
    end
  end

  // Hard stop for a stuck run
  initial begin
    #5_000_000;
    keypad_checker_i.note_failure("simulation time limit reached");
    keypad_checker_i.report();
    $display(">>> FAIL");
    $finish;
  end

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    int n;
    @(posedge clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!axil_rsp.awready && n < HS_LIMIT);
    if (!axil_rsp.awready) keypad_checker_i.note_failure("write was never accepted");
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!axil_rsp.bvalid && n < HS_LIMIT);
    if (!axil_rsp.bvalid) keypad_checker_i.note_failure("write response never came");
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  // Stall holds rready low for that many cycles after rvalid
  task automatic axil_read(input axil_addr_t addr, input int stall, output axil_data_t data);
    int n;
    @(posedge clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!axil_rsp.arready && n < HS_LIMIT);
    if (!axil_rsp.arready) keypad_checker_i.note_failure("read address was never accepted");
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!axil_rsp.rvalid && n < HS_LIMIT);
    if (!axil_rsp.rvalid) keypad_checker_i.note_failure("read data never came");
    repeat (stall) @(negedge clk);
    data = axil_rsp.rdata;
    @(posedge clk);
    axil_req.rready <= 1'b1;
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  // Poll status until the masked bits match
  task automatic wait_status(input axil_data_t mask, input axil_data_t value, input string what);
    axil_data_t d;
    int         n;
    d = '0;
    n = 0;
    do begin
      axil_read(REG_STATUS, 0, d);
      n++;
    end while (((d & mask) != value) && n < POLL_LIMIT);
    if ((d & mask) != value) keypad_checker_i.note_failure({"status never showed ", what});
  endtask

  task automatic release_keys();
    @(posedge clk);
    pressed <= '0;
    // Gap that lets the row synchronizer drain
    repeat (4) @(posedge clk);
  endtask

  // Press rows ra and rb in column c, same row for a single key
  task automatic enter_key(input int ra, input int rb, input int c, input int lvl,
                           input bit lost);
    logic [15:0] mask;
    mask = '0;
    mask[4*ra+c] = 1'b1;
    mask[4*rb+c] = 1'b1;
    if (!lost) begin
      keypad_checker_i.expect_key(row_t'(4'b1000 >> ra) | row_t'(4'b1000 >> rb),
                                  ~col_t'(4'b1000 >> c));
    end
    @(posedge clk);
    pressed <= mask;
    if (lost) wait_status(32'h2, 32'h2, "overflow");
    else wait_status(32'h70, axil_data_t'(lvl) << 4, "next level");
    release_keys();
  endtask

  // Press while the scanner must stay parked
  task automatic press_while_parked(input int r, input int c);
    @(posedge clk);
    pressed <= 16'h1 << (4*r + c);
    repeat (20) begin
      @(negedge clk);
      keypad_checker_i.check_col("parked col", 4'b1111);
    end
    release_keys();
    axil_read(REG_STATUS, 0, rd);
    keypad_checker_i.check_value("status no event", 32'h0, rd);
  endtask

  initial begin
    void'($urandom(32'hed3c_5dfe));
    nRst     = 1'b0;
    axil_req = '0;
    pressed  = '0;
    repeat (10) @(posedge clk);
    nRst <= 1'b1;
    @(posedge clk);

    // Mode 0 parks the columns, then enable 0 keeps them parked
    keypad_checker_i.begin_test("scan_off");
    axil_write(REG_CTRL, 32'h1);
    axil_read(REG_CTRL, 0, rd);
    keypad_checker_i.check_value("ctrl readback", 32'h1, rd);
    press_while_parked($urandom % 4, $urandom % 4);
    axil_write(REG_CTRL, 32'h2);
    axil_read(REG_CTRL, 0, rd);
    keypad_checker_i.check_value("ctrl readback", 32'h2, rd);
    press_while_parked($urandom % 4, $urandom % 4);

    // All 16 keys in shuffled order
    keypad_checker_i.begin_test("scan_on");
    axil_write(REG_CTRL, 32'h3);
    for (int i = 0; i < 16; i++) order[i] = i;
    for (int i = 15; i > 0; i--) begin
      j = $urandom % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 16; i++) begin
      enter_key(order[i] / 4, order[i] / 4, order[i] % 4, 1, 1'b0);
      axil_read(REG_KEY, 0, rd);
    end

    // Long hold gives one event and a fixed column
    keypad_checker_i.begin_test("held_key");
    r0 = $urandom % 4;
    c0 = $urandom % 4;
    keypad_checker_i.expect_key(row_t'(4'b1000 >> r0), ~col_t'(4'b1000 >> c0));
    @(posedge clk);
    pressed <= 16'h1 << (4*r0 + c0);
    wait_status(32'h71, 32'h11, "one entry");
    repeat (40) begin
      @(negedge clk);
      keypad_checker_i.check_col("held col", ~col_t'(4'b1000 >> c0));
    end
    axil_read(REG_STATUS, 0, rd);
    keypad_checker_i.check_value("status while held", 32'h11, rd);
    release_keys();
    axil_read(REG_KEY, 0, rd);
    axil_read(REG_STATUS, 0, rd);
    keypad_checker_i.check_value("status after read", 32'h0, rd);

    // Fifth press is dropped and flags overflow
    keypad_checker_i.begin_test("overflow");
    for (int i = 0; i < 5; i++) begin
      r0 = $urandom % 4;
      c0 = $urandom % 4;
      enter_key(r0, r0, c0, i + 1, i == 4);
    end
    axil_read(REG_STATUS, 0, rd);
    keypad_checker_i.check_value("status full", 32'h43, rd);
    repeat (5) begin
      axil_read(REG_KEY, 0, rd);
    end
    axil_write(REG_STATUS, 32'h2);
    axil_read(REG_STATUS, 0, rd);
    keypad_checker_i.check_value("status cleared", 32'h0, rd);

    // Two rows in one column
    keypad_checker_i.begin_test("two_rows");
    c0 = $urandom % 4;
    r0 = $urandom % 4;
    r1 = (r0 + 1 + $urandom % 3) % 4;
    enter_key(r0, r1, c0, 1, 1'b0);
    axil_read(REG_KEY, 0, rd);

    // Stalled read, then the next entry
    keypad_checker_i.begin_test("backpressure");
    r0 = $urandom % 4;
    c0 = $urandom % 4;
    enter_key(r0, r0, c0, 1, 1'b0);
    r0 = $urandom % 4;
    c0 = $urandom % 4;
    enter_key(r0, r0, c0, 2, 1'b0);
    axil_read(REG_KEY, 8, rd);
    axil_read(REG_KEY, 0, rd);
    axil_read(REG_STATUS, 0, rd);
    keypad_checker_i.check_value("status drained", 32'h0, rd);

    keypad_checker_i.report();
    if (keypad_checker_i.error_total() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- keypad_ctrl.f
verilog/keypad_pkg.sv
verilog/keypad_scanner.sv
verilog/key_entry_fsm.sv
verilog/key_event_fifo.sv
verilog/keypad_axil_slave.sv
verilog/keypad_ctrl_top.sv
tb/keypad_checker.sv
tb/tb_keypad_ctrl.sv

//--- Bender.yml
package:
  name: keypad_ctrl

sources:
  - verilog/keypad_pkg.sv
  - verilog/keypad_scanner.sv
  - verilog/key_entry_fsm.sv
  - verilog/key_event_fifo.sv
  - verilog/keypad_axil_slave.sv
  - verilog/keypad_ctrl_top.sv
  - target: test
    files:
      - tb/keypad_checker.sv
      - tb/tb_keypad_ctrl.sv
